// File: all.f
+incdir+rtl
+incdir+tb
rtl/fas_pkg.sv
rtl/fir_sequencer.sv
rtl/fir_datapath.sv
rtl/frame_slot_counter.sv
rtl/frame_buffer.sv
rtl/fas_top.sv
tb/tb_fas.sv

// File: rtl/fas_consts.svh
// Compile-time constants for the FIR filter and frame collector.
// Include wherever a width, the tap count or a coefficient is needed.
// Coefficients are Q4.16, and only the first half of the symmetric set is listed.

`ifndef FAS_CONSTS_SVH
`define FAS_CONSTS_SVH

//////////////////////////////////////////////////
// Word widths
//////////////////////////////////////////////////

`define FAS_SAMPLE_W   16   // Input sample and filter output
`define FAS_COEF_W     20   // Q4.16 coefficient
`define FAS_ACC_W      42   // Full filter sum

//////////////////////////////////////////////////
// Filter and frame geometry
//////////////////////////////////////////////////

`define FAS_TAPS       32   // Tap k pairs with tap 31-k
`define FAS_FRAME_LEN  16   // Filter outputs per frame
`define FAS_OUT_LSB    16   // Lowest sum bit kept in fir_d

//////////////////////////////////////////////////
// Low-pass coefficients, taps 0 to 15
//////////////////////////////////////////////////

`define FAS_COEF_0     20'shFFF9E  // -0.00150
`define FAS_COEF_1     20'shFFF86  // -0.00186
`define FAS_COEF_2     20'shFFFA7  // -0.00136
`define FAS_COEF_3     20'sh0003B  // 0.00090
`define FAS_COEF_4     20'sh0014B  // 0.00505
`define FAS_COEF_5     20'sh0024A  // 0.00894
`define FAS_COEF_6     20'sh00222  // 0.00833
`define FAS_COEF_7     20'shFFFE4  // -0.00043
`define FAS_COEF_8     20'shFFBC5  // -0.01653
`define FAS_COEF_9     20'shFF7CA  // -0.03207
`define FAS_COEF_10    20'shFF74E  // -0.03397
`define FAS_COEF_11    20'shFFD74  // -0.00995
`define FAS_COEF_12    20'sh00B1A  // 0.04337
`define FAS_COEF_13    20'sh01DAC  // 0.11591
`define FAS_COEF_14    20'sh02F9E  // 0.18600
`define FAS_COEF_15    20'sh03AA9  // Centre pair, 0.22914

`endif

// File: rtl/fas_pkg.sv
// Shared data types of the filter and frame path.
// Modules reference these by scoped name in their ports and import the
// package in their bodies.

`default_nettype none

`include "fas_consts.svh"

package fas_pkg;

  // One input sample or one filter output
  typedef logic signed [`FAS_SAMPLE_W-1:0] sample_t;

  // Q4.16 filter coefficient
  typedef logic signed [`FAS_COEF_W-1:0] coef_t;

  // Full-precision filter sum before slicing
  typedef logic signed [`FAS_ACC_W-1:0] acc_t;

  // Position of an output within its frame
  typedef logic [$clog2(`FAS_FRAME_LEN)-1:0] slot_t;

  // Completed frame, word 0 is the oldest output
  typedef sample_t [`FAS_FRAME_LEN-1:0] frame_t;

endpackage

`default_nettype wire

// File: rtl/fas_top.sv
// Top level of the filter and frame collector.
// Samples enter on data while data_valid is high. Filter outputs leave
// on fir_d with fir_valid, and frames of 16 outputs on frame_d with
// frame_valid. There is no back-pressure on any output.

`timescale 1ns/1ps
`default_nettype none

module fas_top (
  input  wire              clk,
  input  wire              rst,
  input  wire              data_valid,
  input  wire fas_pkg::sample_t data,
  output logic             fir_valid,
  output fas_pkg::sample_t fir_d,
  output logic             frame_valid,
  output fas_pkg::frame_t  frame_d
);

  import fas_pkg::*;

  slot_t slot;       // Slot of the output on fir_d
  logic  last_slot;  // That output closes a frame

  //////////////////////////////////////////////////
  // FIR filter
  //////////////////////////////////////////////////

  fir_sequencer i_fir_sequencer (
    .clk        (clk),
    .rst        (rst),
    .data_valid (data_valid),
    .fir_valid  (fir_valid)
  );

  fir_datapath i_fir_datapath (
    .clk        (clk),
    .rst        (rst),
    .data_valid (data_valid),
    .data       (data),
    .fir_d      (fir_d)
  );

  //////////////////////////////////////////////////
  // Frame collection
  //////////////////////////////////////////////////

  frame_slot_counter i_frame_slot_counter (
    .clk       (clk),
    .rst       (rst),
    .fir_valid (fir_valid),
    .slot      (slot),
    .last_slot (last_slot)
  );

  frame_buffer i_frame_buffer (
    .clk         (clk),
    .rst         (rst),
    .fir_valid   (fir_valid),
    .fir_d       (fir_d),
    .slot        (slot),
    .last_slot   (last_slot),
    .frame_valid (frame_valid),
    .frame_d     (frame_d)
  );

endmodule

`default_nettype wire

// File: rtl/fir_datapath.sv
// Datapath of the 32-tap symmetric FIR filter.
// Each accepted sample enters the tap line and the matching output is
// registered on the same edge. Symmetric taps are added before one multiply.

`timescale 1ns/1ps
`default_nettype none

`include "fas_consts.svh"

module fir_datapath (
  input  wire              clk,
  input  wire              rst,
  input  wire              data_valid,
  input  wire fas_pkg::sample_t data,
  output fas_pkg::sample_t fir_d
);

  import fas_pkg::*;

  localparam int half = `FAS_TAPS / 2;

  // Tap k and tap 31-k share coef_half[k]
  localparam coef_t coef_half [half] = '{
    `FAS_COEF_0,  `FAS_COEF_1,  `FAS_COEF_2,  `FAS_COEF_3,
    `FAS_COEF_4,  `FAS_COEF_5,  `FAS_COEF_6,  `FAS_COEF_7,
    `FAS_COEF_8,  `FAS_COEF_9,  `FAS_COEF_10, `FAS_COEF_11,
    `FAS_COEF_12, `FAS_COEF_13, `FAS_COEF_14, `FAS_COEF_15
  };

  sample_t                       hist_q   [`FAS_TAPS-1];  // Past samples, 0 is the latest
  sample_t                       tap_line [`FAS_TAPS];    // k is the sample taken k steps back
  logic signed [`FAS_SAMPLE_W:0] pair_sum [half];         // One extra bit for the pre-add
  acc_t                          acc_sum;
  sample_t                       fir_next;

  //////////////////////////////////////////////////
  // Tap line as seen after this edge's shift
  //////////////////////////////////////////////////

  always_comb begin
    tap_line[0] = data;
    for (int k = 1; k < `FAS_TAPS; k++) begin
      tap_line[k] = hist_q[k-1];
    end
  end

  //////////////////////////////////////////////////
  // Symmetric multiply-accumulate
  //////////////////////////////////////////////////

  always_comb begin
    acc_sum = '0;
    for (int k = 0; k < half; k++) begin
      pair_sum[k] = tap_line[k] + tap_line[`FAS_TAPS-1-k];
      acc_sum     = acc_sum + pair_sum[k] * coef_half[k];
    end
  end

  // Sign bit, then the integer part down to the binary point
  assign fir_next = {acc_sum[`FAS_ACC_W-1],
                     acc_sum[`FAS_OUT_LSB+`FAS_SAMPLE_W-2:`FAS_OUT_LSB]};

  //////////////////////////////////////////////////
  // Registers
  //////////////////////////////////////////////////

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      for (int k = 0; k < `FAS_TAPS - 1; k++) begin
        hist_q[k] <= '0;
      end
      fir_d <= '0;
    end else if (!data_valid) begin
      // End of burst, next burst starts from an empty tap line
      for (int k = 0; k < `FAS_TAPS - 1; k++) begin
        hist_q[k] <= '0;
      end
      fir_d <= '0;
    end else begin
      for (int k = 0; k < `FAS_TAPS - 1; k++) begin
        hist_q[k] <= tap_line[k];  // Oldest tap drops off the end
      end
      fir_d <= fir_next;
    end
  end

endmodule

`default_nettype wire

// File: rtl/fir_sequencer.sv
// Burst state machine of the FIR filter.
// Counts the samples of a burst until the tap line is full and then
// flags fir_valid for every further output. A low data_valid ends the burst.

`timescale 1ns/1ps
`default_nettype none

`include "fas_consts.svh"

module fir_sequencer (
  input  wire  clk,
  input  wire  rst,
  input  wire  data_valid,
  output logic fir_valid
);

  localparam int cnt_w = $clog2(`FAS_TAPS + 1);

  typedef enum logic [1:0] {
    st_idle,    // No burst in progress
    st_fill,    // Tap line still partly empty
    st_stream   // Every output is a full filter result
  } seq_state_t;

  seq_state_t       state_q;
  seq_state_t       state_d;
  logic [cnt_w-1:0] fill_cnt_q;  // Samples taken so far, saturates at the tap count
  logic [cnt_w-1:0] fill_cnt_d;
  logic             last_fill;

  // The sample arriving now completes the tap line
  assign last_fill = (fill_cnt_q == cnt_w'(`FAS_TAPS - 1));

  //////////////////////////////////////////////////
  // Next state
  //////////////////////////////////////////////////

  always_comb begin
    state_d    = state_q;
    fill_cnt_d = fill_cnt_q;
    if (!data_valid) begin
      state_d    = st_idle;   // Burst over, start again from empty
      fill_cnt_d = '0;
    end else begin
      case (state_q)
        st_idle, st_fill: begin
          fill_cnt_d = fill_cnt_q + 1'b1;
          state_d    = last_fill ? st_stream : st_fill;
        end
        st_stream: begin
          state_d = st_stream;    // Count stays at the tap count
        end
        default: begin
          state_d    = st_idle;
          fill_cnt_d = '0;
        end
      endcase
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state_q    <= st_idle;
      fill_cnt_q <= '0;
    end else begin
      state_q    <= state_d;
      fill_cnt_q <= fill_cnt_d;
    end
  end

  // High in each cycle after a 32nd or later sample
  assign fir_valid = (state_q == st_stream);

endmodule

`default_nettype wire

// File: rtl/frame_buffer.sv
// Serial-to-parallel buffer of the frame collector.
// Stores each valid filter output at its slot and, with the last slot,
// publishes the whole frame on frame_d together with a one-cycle frame_valid.
// The published frame holds while the next one is collected.

`timescale 1ns/1ps
`default_nettype none

module frame_buffer (
  input  wire              clk,
  input  wire              rst,
  input  wire              fir_valid,
  input  wire fas_pkg::sample_t fir_d,
  input  wire fas_pkg::slot_t   slot,
  input  wire              last_slot,
  output logic             frame_valid,
  output fas_pkg::frame_t  frame_d
);

  import fas_pkg::*;

  frame_t collect_q;  // Frame under collection
  frame_t merged;     // Collection with the current output in place
  logic   publish;

  always_comb begin
    merged       = collect_q;
    merged[slot] = fir_d;
  end

  assign publish = fir_valid & last_slot;

  //////////////////////////////////////////////////
  // Collection buffer
  //////////////////////////////////////////////////

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      collect_q <= '0;
    end else if (fir_valid) begin
      collect_q <= merged;
    end
  end

  //////////////////////////////////////////////////
  // Published frame
  //////////////////////////////////////////////////

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      frame_valid <= 1'b0;
      frame_d     <= '0;
    end else begin
      frame_valid <= publish;   // Single-cycle pulse
      if (publish) begin
        frame_d <= merged;
      end
    end
  end

endmodule

`default_nettype wire

// File: rtl/frame_slot_counter.sv
// Slot counter of the frame collector.
// Steps through the frame slots on every valid filter output and
// falls back to slot 0 as soon as the output stream breaks.

`timescale 1ns/1ps
`default_nettype none

`include "fas_consts.svh"

module frame_slot_counter (
  input  wire            clk,
  input  wire            rst,
  input  wire            fir_valid,
  output fas_pkg::slot_t slot,
  output logic           last_slot
);

  import fas_pkg::*;

  assign last_slot = (slot == slot_t'(`FAS_FRAME_LEN - 1));

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      slot <= '0;
    end else if (!fir_valid) begin
      slot <= '0;          // Partial frame is dropped
    end else if (last_slot) begin
      slot <= '0;          // Frame complete, wrap
    end else begin
      slot <= slot + 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# Builds the testbench and RTL with Verilator and runs the simulation into sim.log.
# Exits non-zero when the build fails or the log reports a failure.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_fas -f all.f -o tb_fas_sim \
  && ./obj_dir/tb_fas_sim > sim.log 2>&1 \
  || { echo "build or run failed"; exit 1; }

cat sim.log
grep -q "Simulation finished: FAIL" sim.log && { echo "failure found in sim.log"; exit 1; }
exit 0

// File: tb/tb_fas_ref.svh
// Reference model of the FIR filter and frame collector, plus the random source.
// Included inside the testbench module body after the fas_pkg import.

`ifndef TB_FAS_REF_SVH
`define TB_FAS_REF_SVH

logic [31:0] rng_state = 32'hfa35ec68;

sample_t ref_hist [`FAS_TAPS];  // Index 0 is the newest sample
int      burst_len;             // Samples taken in this burst up to the tap count
logic    exp_fir_valid;
sample_t exp_fir_d;
logic    exp_frame_valid;
frame_t  exp_frame_d;
frame_t  collect;               // Expected outputs of the frame in progress
int      collect_cnt;

//////////////////////////////////////////////////
// Random numbers
//////////////////////////////////////////////////

function automatic logic [31:0] xorshift32(input logic [31:0] x);
  logic [31:0] y;
  y = x ^ (x << 13);
  y = y ^ (y >> 17);
  y = y ^ (y << 5);
  return y;
endfunction

function automatic logic [31:0] next_random();
  rng_state = xorshift32(rng_state);
  return rng_state;
endfunction

//////////////////////////////////////////////////
// Filter reference
//////////////////////////////////////////////////

// Coefficient of tap k, mirrored about the centre
function automatic longint coef_at(input int k);
  int m;
  m = (k < `FAS_TAPS / 2) ? k : `FAS_TAPS - 1 - k;
  case (m)
    0:       return `FAS_COEF_0;
    1:       return `FAS_COEF_1;
    2:       return `FAS_COEF_2;
    3:       return `FAS_COEF_3;
    4:       return `FAS_COEF_4;
    5:       return `FAS_COEF_5;
    6:       return `FAS_COEF_6;
    7:       return `FAS_COEF_7;
    8:       return `FAS_COEF_8;
    9:       return `FAS_COEF_9;
    10:      return `FAS_COEF_10;
    11:      return `FAS_COEF_11;
    12:      return `FAS_COEF_12;
    13:      return `FAS_COEF_13;
    14:      return `FAS_COEF_14;
    default: return `FAS_COEF_15;
  endcase
endfunction

// Direct-form sum over the model history, then sign bit and bits 30 to 16
function automatic sample_t fir_reference();
  longint      acc;
  logic [63:0] bits;
  acc = 0;
  for (int k = 0; k < `FAS_TAPS; k++) begin
    acc = acc + coef_at(k) * longint'(ref_hist[k]);
  end
  bits = acc;
  return {(acc < 0), bits[`FAS_OUT_LSB+`FAS_SAMPLE_W-2:`FAS_OUT_LSB]};
endfunction

//////////////////////////////////////////////////
// Cycle model
//////////////////////////////////////////////////

task automatic clear_model();
  for (int k = 0; k < `FAS_TAPS; k++) begin
    ref_hist[k] = '0;
  end
  burst_len       = 0;
  exp_fir_valid   = 1'b0;
  exp_fir_d       = '0;
  exp_frame_valid = 1'b0;
  exp_frame_d     = '0;
  collect         = '0;
  collect_cnt     = 0;
endtask

// One rising edge with the inputs seen at that edge
task automatic advance_model(input logic dv, input sample_t din);
  exp_frame_valid = 1'b0;
  if (exp_fir_valid) begin
    collect[collect_cnt] = exp_fir_d;  // Output shown in the cycle before this edge
    if (collect_cnt == `FAS_FRAME_LEN - 1) begin
      exp_frame_d     = collect;
      exp_frame_valid = 1'b1;
      collect_cnt     = 0;
    end else begin
      collect_cnt++;
    end
  end else begin
    collect     = '0;                  // Stream broke, partial frame is gone
    collect_cnt = 0;
  end
  if (dv) begin
    for (int k = `FAS_TAPS - 1; k > 0; k--) begin
      ref_hist[k] = ref_hist[k-1];
    end
    ref_hist[0] = din;
    if (burst_len < `FAS_TAPS) begin
      burst_len++;
    end
    exp_fir_d     = fir_reference();
    exp_fir_valid = (burst_len == `FAS_TAPS);
  end else begin
    for (int k = 0; k < `FAS_TAPS; k++) begin
      ref_hist[k] = '0;
    end
    burst_len     = 0;
    exp_fir_d     = '0;
    exp_fir_valid = 1'b0;
  end
endtask

`endif

// File: tb/tb_fas.sv
// Testbench for the FIR filter and frame collector.
// Sends an impulse and random bursts into the DUT, compares every output in
// every cycle with the reference model and ends with an error count.

`timescale 1ns/1ps
`default_nettype none

`include "fas_consts.svh"

module tb_fas;

  import fas_pkg::*;

  logic    clk = 1'b0;
  logic    rst;
  logic    data_valid;
  sample_t data;
  logic    fir_valid;
  sample_t fir_d;
  logic    frame_valid;
  frame_t  frame_d;

  int mismatches  = 0;
  int failures    = 0;  // Timeouts and missing activity
  int frames_seen = 0;

  `include "tb_fas_ref.svh"

  fas_top i_fas_top (
    .clk         (clk),
    .rst         (rst),
    .data_valid  (data_valid),
    .data        (data),
    .fir_valid   (fir_valid),
    .fir_d       (fir_d),
    .frame_valid (frame_valid),
    .frame_d     (frame_d)
  );

  always #4 clk = ~clk;  // 8 ns period

  initial clear_model();

  // Model takes the same inputs as the DUT at each rising edge
  always @(posedge clk) begin
    if (rst) begin
      clear_model();
    end else begin
      advance_model(data_valid, data);
    end
  end

  task automatic note_mismatch(input string msg);
    mismatches++;
    $display("mismatch at %0d ns: %s", $time, msg);
  endtask

  //////////////////////////////////////////////////
  // Comparison at the falling edge
  //////////////////////////////////////////////////

  always @(negedge clk) begin
    if (fir_valid !== exp_fir_valid) begin
      note_mismatch($sformatf("fir_valid %b expected %b", fir_valid, exp_fir_valid));
    end
    if (fir_d !== exp_fir_d) begin
      note_mismatch($sformatf("fir_d %0d expected %0d", fir_d, exp_fir_d));
    end
    if (frame_valid !== exp_frame_valid) begin
      note_mismatch($sformatf("frame_valid %b expected %b", frame_valid, exp_frame_valid));
    end
    if (frame_d !== exp_frame_d) begin
      note_mismatch($sformatf("frame_d %h expected %h", frame_d, exp_frame_d));
    end
    if (frame_valid === 1'b1) begin
      frames_seen++;
    end
  end

  //////////////////////////////////////////////////
  // Stimulus tasks
  //////////////////////////////////////////////////

  task automatic drive_sample(input sample_t value);
    @(posedge clk);
    #1;
    data_valid = 1'b1;
    data       = value;
  endtask

  task automatic drive_idle(input int cycles);
    repeat (cycles) begin
      @(posedge clk);
      #1;
      data_valid = 1'b0;
      data       = '0;
    end
  endtask

  task automatic drive_random(input int count);
    logic [31:0] rnd;
    repeat (count) begin
      rnd = next_random();
      drive_sample(rnd[15:0]);
    end
  endtask

  // Keeps the burst going until a frame comes out
  task automatic stream_until_frame(input int max_cycles);
    logic [31:0] rnd;
    logic        seen;
    int          cycles;
    seen   = 1'b0;
    cycles = 0;
    while (!seen && cycles < max_cycles) begin
      rnd = next_random();
      drive_sample(rnd[15:0]);
      @(negedge clk);
      if (frame_valid === 1'b1) begin
        seen = 1'b1;
      end
      cycles++;
    end
    if (!seen) begin
      failures++;
      $display("timeout: frame_valid did not pulse within %0d samples", max_cycles);
    end
  endtask

  // 31 zeros, then 16384, then zeros while each output is checked
  task automatic check_impulse();
    sample_t expected;
    repeat (`FAS_TAPS - 1) drive_sample('0);
    drive_sample(16'sd16384);
    for (int age = 0; age < `FAS_TAPS; age++) begin
      drive_sample('0);
      @(negedge clk);
      expected = sample_t'(coef_at(age) >>> 2);  // 16384 is a quarter in Q4.16
      if (fir_valid !== 1'b1 || fir_d !== expected) begin
        note_mismatch($sformatf("impulse age %0d fir_d %0d valid %b expected %0d",
                                age, fir_d, fir_valid, expected));
      end
    end
  endtask

  //////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////

  initial begin : stimulus
    logic [31:0] rnd;
    rst        = 1'b1;
    data_valid = 1'b0;
    data       = '0;
    repeat (3) @(posedge clk);
    #1;
    rst = 1'b0;
    drive_idle(4);                  // Outputs stay quiet before any sample
    check_impulse();
    drive_idle(2);
    drive_random(`FAS_TAPS);        // Long random burst
    repeat (3) stream_until_frame(2 * `FAS_FRAME_LEN);
    rnd = next_random();
    drive_random(int'(rnd % 32'd7));
    drive_idle(2);
    rnd = next_random();            // Break inside a frame
    drive_random(`FAS_TAPS + 3 + int'(rnd % 32'd10));
    drive_idle(1);
    rnd = next_random();            // Too short to fill the taps
    drive_random(5 + int'(rnd % 32'd20));
    drive_idle(3);
    drive_random(`FAS_TAPS);        // Restart from cleared taps
    repeat (2) stream_until_frame(2 * `FAS_FRAME_LEN);
    drive_idle(2);
    repeat (6) begin
      rnd = next_random();
      drive_random(20 + int'(rnd % 32'd70));
      rnd = next_random();
      drive_idle(1 + int'(rnd % 32'd4));
    end
    drive_idle(4);
    if (frames_seen == 0) begin
      failures++;
      $display("no frame was published during the run");
    end
    $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
    if (mismatches == 0 && failures == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire
